// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build $(TOP) with Verilator, run it, fail unless it passes"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
design/fetch_pkg.sv
design/insn_decode.sv
design/imm_extract.sv
design/unified_mem.sv
design/mem_arbiter.sv
design/fetch_unit.sv
design/fetch_top.sv
sim/fetch_checker.sv
sim/tb_fetch.sv

// File: design/fetch_pkg.sv
package fetch_pkg;

  // instruction word width
  localparam int INSN_W = 32;

  // unified memory geometry, word addressed
  localparam int MEM_WORDS = 256;
  localparam int ADDR_W = 8;

  // program counter width, byte addressed
  localparam int PC_W = 64;

  // byte address loaded into the pc on reset
  localparam logic [PC_W-1:0] ENTRY_PC = '0;

  // fixed encoding fields used by the classifier
  // unconditional branch, bits 31..26
  localparam logic [5:0] B_OP6 = 6'b000101;
  // branch with link, bits 31..26
  localparam logic [5:0] BL_OP6 = 6'b100101;
  // conditional branch, bits 31..24, bit 4 must be clear
  localparam logic [7:0] BCOND_OP8 = 8'b01010100;

  // ret with any rn: rn sits in bits 9..5 and is masked off
  localparam logic [INSN_W-1:0] RET_MASK = 32'hfffffc1f;
  localparam logic [INSN_W-1:0] RET_MATCH = 32'hd65f0000;

  // canonical hint nop
  localparam logic [INSN_W-1:0] NOP_WORD = 32'hd503201f;

  // instruction classes seen by fetch
  typedef enum logic [2:0] {
    OP_NOP,
    OP_B,
    OP_BL,
    OP_BCOND,
    OP_RET,
    OP_OTHER
  } opcode_t;

  // one access to the unified memory
  typedef struct packed {
    // access wanted this cycle
    logic req;
    // write when set, read otherwise
    logic we;
    // word address
    logic [ADDR_W-1:0] addr;
    // write data, ignored on reads
    logic [INSN_W-1:0] wdata;
  } mem_req_t;

  // one fetched instruction as handed downstream
  typedef struct packed {
    // byte address of the instruction
    logic [PC_W-1:0] pc;
    // raw instruction bits
    logic [INSN_W-1:0] insn;
    // decoded class
    opcode_t opcode;
  } fetch_out_t;

endpackage

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
  input  logic                         in_clk,
  input  logic                         in_rst,
  input  logic                         load_we,
  input  logic [fetch_pkg::ADDR_W-1:0] load_addr,
  input  logic [fetch_pkg::INSN_W-1:0] load_data,
  input  logic                         run,
  output logic                         fetch_valid,
  output fetch_pkg::fetch_out_t        fetch_out,
  output logic                         halted
);
  import fetch_pkg::*;

  // request from the program load port
  mem_req_t          load_req;
  // request from the fetch unit
  mem_req_t          fetch_req;
  // winner that drives the memory
  mem_req_t          mem_req;
  logic              fetch_gnt;
  // registered read data back to fetch
  logic [INSN_W-1:0] rdata;

  // load strobe becomes a one-cycle write request
  assign load_req.req = load_we;
  assign load_req.we = 1'b1;
  assign load_req.addr = load_addr;
  assign load_req.wdata = load_data;

  // load port first, fetch only in free cycles
  mem_arbiter u_arb (
    .load_req  (load_req),
    .fetch_req (fetch_req),
    .mem_req   (mem_req),
    .fetch_gnt (fetch_gnt)
  );

  unified_mem u_mem (
    .in_clk  (in_clk),
    .mem_req (mem_req),
    .rdata   (rdata)
  );

  fetch_unit u_fetch (
    .in_clk      (in_clk),
    .in_rst      (in_rst),
    .run         (run),
    .fetch_gnt   (fetch_gnt),
    .rdata       (rdata),
    .fetch_req   (fetch_req),
    .fetch_valid (fetch_valid),
    .fetch_out   (fetch_out),
    .halted      (halted)
  );

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                         in_clk,
  input  logic                         in_rst,
  input  logic                         run,
  input  logic                         fetch_gnt,
  input  logic [fetch_pkg::INSN_W-1:0] rdata,
  output fetch_pkg::mem_req_t          fetch_req,
  output logic                         fetch_valid,
  output fetch_pkg::fetch_out_t        fetch_out,
  output logic                         halted
);
  import fetch_pkg::*;

  // issue a read, wait one cycle for data, or stop for good
  typedef enum logic [1:0] {
    ISSUE,
    WAIT_DATA,
    HALT
  } state_t;

  state_t          state;
  // byte pc of the word in flight
  logic [PC_W-1:0] pc;
  // request went out but lost to a load write
  logic            req_hold;
  opcode_t         opcode;
  logic [PC_W-1:0] offset;
  logic            taken;
  logic            word_zero;
  logic [PC_W-1:0] next_pc;

  // classify the returned word
  insn_decode u_decode (
    .insn   (rdata),
    .opcode (opcode)
  );

  // branch offset, zero for non-branches
  imm_extract u_imm (
    .insn   (rdata),
    .opcode (opcode),
    .offset (offset)
  );

  // an all-zero word ends the program
  assign word_zero = (rdata == '0);

  // every direct branch is predicted taken, b.cond included
  assign taken = (opcode == OP_B) || (opcode == OP_BL) || (opcode == OP_BCOND);
  assign next_pc = taken ? (pc + offset) : (pc + PC_W'(4));

  // read request at the word address of the pc
  // once raised it stays up until granted even if run drops
  always_comb begin
    fetch_req.req = (state == ISSUE) && (run || req_hold);
    fetch_req.we = 1'b0;
    fetch_req.addr = pc[ADDR_W+1:2];
    fetch_req.wdata = '0;
  end

  // output is built from registered pc and registered read data
  // valid only in the cycle the word comes back
  assign fetch_valid = (state == WAIT_DATA) && !word_zero;
  assign fetch_out.pc = pc;
  assign fetch_out.insn = rdata;
  assign fetch_out.opcode = opcode;

  // level, held until reset
  assign halted = (state == HALT);

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      state <= ISSUE;
      pc <= ENTRY_PC;
      req_hold <= 1'b0;
    end else begin
      case (state)
        ISSUE: begin
          if (fetch_req.req) begin
            if (fetch_gnt) begin
              // data comes back next cycle
              state <= WAIT_DATA;
              req_hold <= 1'b0;
            end else begin
              // lost to the load port, try again with the same address
              req_hold <= 1'b1;
            end
          end
        end
        WAIT_DATA: begin
          if (word_zero) begin
            state <= HALT;
          end else begin
            // predicted pc, next request goes out next cycle
            pc <= next_pc;
            state <= ISSUE;
          end
        end
        default: begin
          // halt is sticky
          state <= HALT;
        end
      endcase
    end
  end

endmodule

// File: design/imm_extract.sv
`timescale 1ns/1ps

module imm_extract (
  input  logic [fetch_pkg::INSN_W-1:0] insn,
  input  fetch_pkg::opcode_t           opcode,
  output logic [fetch_pkg::PC_W-1:0]   offset
);
  import fetch_pkg::*;

  // byte offsets for the two branch formats
  logic [PC_W-1:0] off_imm26;
  logic [PC_W-1:0] off_imm19;

  // imm26 in bits 25..0, times four, sign from bit 25
  assign off_imm26 = {{(PC_W-28){insn[25]}}, insn[25:0], 2'b00};

  // imm19 in bits 23..5, times four, sign from bit 23
  assign off_imm19 = {{(PC_W-21){insn[23]}}, insn[23:5], 2'b00};

  // select by class
  // non-branches get zero so the pc adder never sees stray fields
  always_comb begin
    case (opcode)
      OP_B, OP_BL: begin
        offset = off_imm26;
      end
      OP_BCOND: begin
        offset = off_imm19;
      end
      default: begin
        offset = '0;
      end
    endcase
  end

endmodule

// File: design/insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
  input  logic [fetch_pkg::INSN_W-1:0] insn,
  output fetch_pkg::opcode_t           opcode
);
  import fetch_pkg::*;

  // field slices pulled out once
  logic [5:0] op6;
  logic [7:0] op8;
  logic       cond_bit4;
  logic       is_ret;
  logic       is_nop;

  // major opcode for b and bl
  assign op6 = insn[31:26];
  // major opcode for b.cond
  assign op8 = insn[31:24];
  // b.cond requires bit 4 low, otherwise it is bc.cond or unallocated
  assign cond_bit4 = insn[4];

  // ret ignores the rn field
  assign is_ret = (insn & RET_MASK) == RET_MATCH;
  // only the exact hint word counts as nop
  assign is_nop = (insn == NOP_WORD);

  // classes do not overlap, the order only matters for readability
  always_comb begin
    if (is_nop) begin
      opcode = OP_NOP;
    end else if (is_ret) begin
      opcode = OP_RET;
    end else if (op6 == B_OP6) begin
      // imm26 direct branch
      opcode = OP_B;
    end else if (op6 == BL_OP6) begin
      // imm26 direct branch, writes x30 later in the pipe
      opcode = OP_BL;
    end else if ((op8 == BCOND_OP8) && !cond_bit4) begin
      // imm19 conditional branch
      opcode = OP_BCOND;
    end else begin
      // anything fetch does not care about
      opcode = OP_OTHER;
    end
  end

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  fetch_pkg::mem_req_t load_req,
  input  fetch_pkg::mem_req_t fetch_req,
  output fetch_pkg::mem_req_t mem_req,
  output logic                fetch_gnt
);

  // load port has no stall path, so it always takes the port
  logic load_win;

  assign load_win = load_req.req;

  // fixed priority mux, load first
  // with no load the fetch request passes through, idle or not
  always_comb begin
    if (load_win) begin
      mem_req = load_req;
    end else begin
      mem_req = fetch_req;
    end
  end

  // fetch owns the port only in a cycle without a load write
  // the fetch unit keeps its request up until it sees this
  assign fetch_gnt = fetch_req.req && !load_win;

endmodule

// File: design/unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
  input  logic                         in_clk,
  input  fetch_pkg::mem_req_t          mem_req,
  output logic [fetch_pkg::INSN_W-1:0] rdata
);
  import fetch_pkg::*;

  // word array shared by program load and instruction fetch
  // contents start undefined, every used word is written first
  logic [INSN_W-1:0] mem [MEM_WORDS];

  // single synchronous port
  // write lands at the end of the granted cycle
  // read data shows up in the following cycle
  always_ff @(posedge in_clk) begin
    if (mem_req.req) begin
      if (mem_req.we) begin
        mem[mem_req.addr] <= mem_req.wdata;
      end else begin
        // rdata keeps its value across writes and idle cycles
        rdata <= mem[mem_req.addr];
      end
    end
  end

endmodule

// File: sim/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
  input  logic                         in_clk,
  input  logic                         in_rst,
  input  logic                         load_we,
  input  logic [fetch_pkg::ADDR_W-1:0] load_addr,
  input  logic [fetch_pkg::INSN_W-1:0] load_data,
  input  logic                         run,
  input  logic                         fetch_valid,
  input  fetch_pkg::fetch_out_t        fetch_out,
  input  logic                         halted,
  input  int                           expected_fetches,
  output int                           error_count,
  output int                           valid_count
);
  import fetch_pkg::*;

  // copy of every word written through the load port
  logic [INSN_W-1:0] mirror [MEM_WORDS];
  // predicted pc of the next fetched instruction
  logic [PC_W-1:0]   exp_pc;
  logic [INSN_W-1:0] exp_word;
  opcode_t           exp_opcode;
  // run has been high at least once since reset
  logic              run_seen;
  logic              halt_seen;
  logic              prev_valid;

  // instruction classes straight from the encoding rules
  function automatic opcode_t classify_word(input logic [INSN_W-1:0] w);
    opcode_t op;
    if (w == 32'hd503201f) begin
      op = OP_NOP;
    end else if (w[31:10] == 22'b1101011001011111000000 && w[4:0] == 5'b00000) begin
      // ret, rn in bits 9..5 is free
      op = OP_RET;
    end else if (w[31:26] == 6'b000101) begin
      op = OP_B;
    end else if (w[31:26] == 6'b100101) begin
      op = OP_BL;
    end else if (w[31:24] == 8'h54 && w[4] == 1'b0) begin
      op = OP_BCOND;
    end else begin
      op = OP_OTHER;
    end
    return op;
  endfunction

  // branches predicted taken, everything else falls through
  function automatic logic [PC_W-1:0] predict_next_pc(input logic [PC_W-1:0] pc,
                                                      input logic [INSN_W-1:0] w,
                                                      input opcode_t op);
    logic [PC_W-1:0] step;
    case (op)
      OP_B, OP_BL: begin
        step = {{(PC_W-26){w[25]}}, w[25:0]} << 2;
      end
      OP_BCOND: begin
        step = {{(PC_W-19){w[23]}}, w[23:5]} << 2;
      end
      default: begin
        step = PC_W'(4);
      end
    endcase
    return pc + step;
  endfunction

  // word the fetch unit should return at the predicted pc
  assign exp_word = mirror[exp_pc[ADDR_W+1:2]];
  assign exp_opcode = classify_word(exp_word);

  always @(posedge in_clk) begin
    if (in_rst) begin
      exp_pc <= ENTRY_PC;
      run_seen <= 1'b0;
      halt_seen <= 1'b0;
      prev_valid <= 1'b0;
      error_count = 0;
      valid_count = 0;
    end else begin
      if (run) begin
        run_seen <= 1'b1;
      end
      // idle unit before the first run
      if (!run_seen && !run && (fetch_valid !== 1'b0 || halted !== 1'b0)) begin
        $display("ERROR %0t: fetch_valid or halted high before run", $time);
        error_count++;
      end
      if (fetch_valid) begin
        valid_count++;
        if (halt_seen || halted) begin
          $display("ERROR %0t: fetch_valid after halt", $time);
          error_count++;
        end
        // at most one instruction per two cycles
        if (prev_valid) begin
          $display("ERROR %0t: fetch_valid high two cycles in a row", $time);
          error_count++;
        end
        if (fetch_out.pc !== exp_pc) begin
          $display("ERROR %0t: pc %h, expected %h", $time, fetch_out.pc, exp_pc);
          error_count++;
        end
        if (fetch_out.insn !== exp_word) begin
          $display("ERROR %0t: insn %h at pc %h, expected %h",
                   $time, fetch_out.insn, exp_pc, exp_word);
          error_count++;
        end
        if (fetch_out.opcode !== exp_opcode) begin
          $display("ERROR %0t: opcode %s at pc %h, expected %s",
                   $time, fetch_out.opcode.name(), exp_pc, exp_opcode.name());
          error_count++;
        end
        exp_pc <= predict_next_pc(exp_pc, exp_word, exp_opcode);
      end
      if (halted && !halt_seen) begin
        halt_seen <= 1'b1;
        // halt only on a zero word at the predicted pc
        if (exp_word !== '0) begin
          $display("ERROR %0t: halted at pc %h holding %h, expected a zero word",
                   $time, exp_pc, exp_word);
          error_count++;
        end
        if (valid_count != expected_fetches) begin
          $display("ERROR %0t: %0d fetches before halt, expected %0d",
                   $time, valid_count, expected_fetches);
          error_count++;
        end
      end
      if (halt_seen && halted !== 1'b1) begin
        $display("ERROR %0t: halted dropped before reset", $time);
        error_count++;
      end
      // compare above sees memory before this cycle's write
      if (load_we) begin
        mirror[load_addr] <= load_data;
      end
      prev_valid <= fetch_valid;
    end
  end

endmodule

// File: sim/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;
  import fetch_pkg::*;

  localparam int CLK_HALF = 50;
  localparam int NUM_ENTRIES = 19;
  // pulses on the path 0,4,8,28,2c,5c,20,24,18,1c,78,7c,84 before the zero at 88
  localparam int EXP_FETCHES = 13;
  localparam int HALT_TIMEOUT = 400;

  // one program word with a flag for a store issued while fetch runs
  typedef struct packed {
    logic              rewrite;
    logic [ADDR_W-1:0] addr;
    logic [INSN_W-1:0] word;
  } prog_entry_t;

  logic              in_clk;
  logic              in_rst;
  logic              load_we;
  logic [ADDR_W-1:0] load_addr;
  logic [INSN_W-1:0] load_data;
  logic              run;
  logic              fetch_valid;
  fetch_out_t        fetch_out;
  logic              halted;
  int                error_count;
  int                valid_count;
  int                timeout_count;
  integer            seed;
  prog_entry_t       prog [NUM_ENTRIES];

  fetch_top u_dut (
    .in_clk      (in_clk),
    .in_rst      (in_rst),
    .load_we     (load_we),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .run         (run),
    .fetch_valid (fetch_valid),
    .fetch_out   (fetch_out),
    .halted      (halted)
  );

  fetch_checker u_check (
    .in_clk           (in_clk),
    .in_rst           (in_rst),
    .load_we          (load_we),
    .load_addr        (load_addr),
    .load_data        (load_data),
    .run              (run),
    .fetch_valid      (fetch_valid),
    .fetch_out        (fetch_out),
    .halted           (halted),
    .expected_fetches (EXP_FETCHES),
    .error_count      (error_count),
    .valid_count      (valid_count)
  );

  initial begin
    in_clk = 1'b0;
    forever #CLK_HALF in_clk = ~in_clk;
  end

  task automatic fill_program_table();
    prog[0]  = '{1'b0, 8'd0,   32'h8b030041};  // add falls through
    prog[1]  = '{1'b0, 8'd1,   32'hd503201f};  // nop
    prog[2]  = '{1'b0, 8'd2,   32'h14000008};  // b +0x20
    prog[3]  = '{1'b0, 8'd10,  32'hd65f03c0};  // ret x30 falls through
    prog[4]  = '{1'b0, 8'd11,  32'h54000180};  // b.eq +0x30
    prog[5]  = '{1'b0, 8'd23,  32'h97fffff1};  // bl -0x3c
    prog[6]  = '{1'b0, 8'd8,   32'hd2800020};  // movz
    prog[7]  = '{1'b0, 8'd9,   32'h54ffffa1};  // b.ne -0xc
    prog[8]  = '{1'b0, 8'd6,   32'hd65f0020};  // ret x1
    prog[9]  = '{1'b0, 8'd7,   32'h14000017};  // b +0x5c
    prog[10] = '{1'b0, 8'd30,  32'hd503201f};  // nop until the store below replaces it
    prog[11] = '{1'b0, 8'd31,  32'h94000002};  // bl +0x8
    prog[12] = '{1'b0, 8'd33,  32'hcb020020};  // sub
    prog[13] = '{1'b0, 8'd34,  32'h00000000};  // end of program
    // stores while running
    prog[14] = '{1'b1, 8'd30,  32'h54000190};  // bit 4 set so it decodes as other
    prog[15] = '{1'b1, 8'd120, 32'h12345678};
    prog[16] = '{1'b1, 8'd200, 32'hdeadbeef};
    prog[17] = '{1'b1, 8'd5,   32'h8b000000};
    prog[18] = '{1'b1, 8'd32,  32'h00000000};  // hole skipped by bl
  endtask

  // idle gap of 0 to 2 cycles between load strobes
  function automatic int unsigned next_gap();
    return $unsigned($random(seed)) % 3;
  endfunction

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge in_clk);
  endtask

  // one-cycle write strobe
  task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [INSN_W-1:0] word);
    @(posedge in_clk);
    load_we <= 1'b1;
    load_addr <= addr;
    load_data <= word;
    @(posedge in_clk);
    load_we <= 1'b0;
  endtask

  task automatic wait_for_halt(output logic ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < HALT_TIMEOUT) begin
      @(posedge in_clk);
      cycles++;
      if (halted === 1'b1) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("timeout: halted did not rise within %0d cycles of run", HALT_TIMEOUT);
      timeout_count++;
    end
  endtask

  initial begin
    logic halt_ok;
    in_rst = 1'b1;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    run = 1'b0;
    seed = 32'hbbd9b116;
    timeout_count = 0;
    fill_program_table();
    repeat (3) @(posedge in_clk);
    in_rst <= 1'b0;
    // unit sits idle while run is low
    idle_cycles(4);
    // program image goes in before fetch starts
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (!prog[i].rewrite) begin
        write_word(prog[i].addr, prog[i].word);
        idle_cycles(next_gap());
      end
    end
    idle_cycles(2);
    @(posedge in_clk);
    run <= 1'b1;
    // first store lands on the cycle of the second fetch request
    idle_cycles(1);
    // stores that compete with fetch for the port
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (prog[i].rewrite) begin
        write_word(prog[i].addr, prog[i].word);
        idle_cycles(next_gap());
      end
    end
    wait_for_halt(halt_ok);
    if (halt_ok) begin
      // halted must hold with no further fetches
      idle_cycles(10);
    end
    $display("summary: %0d fetches, %0d errors, %0d timeouts",
             valid_count, error_count, timeout_count);
    if (timeout_count == 0 && error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
